// File: common/nvme_host_settings.svh
`ifndef NVME_HOST_SETTINGS_SVH
`define NVME_HOST_SETTINGS_SVH

// AXI geometry
`define NVME_ADDR_W 32
`define NVME_DATA_W 256
`define NVME_STRB_W 32
`define NVME_ID_W 4
`define NVME_LEN_W 8
`define NVME_TAIL_W 32

// Controller BAR and the I/O SQ tail doorbell
`define NVME_CTRL_BASE 32'h8000_4000
`define NVME_DOORBELL_ADDR (`NVME_CTRL_BASE + 32'h0000_1008)

// Host memory windows
`define NVME_SQ_BASE 32'h0000_B000
`define NVME_SQ_END 32'h0000_C000
`define NVME_CQ_BASE 32'h0000_A000
`define NVME_CQ_END 32'h0000_B000

// Command template fields
`define NVME_PRP1 32'h0000_C000
`define NVME_META_PTR 32'h0000_D000
`define NVME_SLBA 32'h0000_1000

`define NVME_WR_PATTERN {2{32'h1234_1234, 32'h5678_5678, 32'h90ab_90ab, 32'hcdef_cdef}}

`define NVME_FIFO_DEPTH 8

`endif

// File: common/nvme_host_pkg.sv
`include "nvme_host_settings.svh"

package nvme_host_pkg;

  // One AR or AW request as it sits in a FIFO
  typedef struct packed {
    logic [`NVME_ADDR_W-1:0] addr;
    logic [`NVME_ID_W-1:0]   id;
    logic [`NVME_LEN_W-1:0]  len;
  } addr_req_t;

  typedef struct packed {
    logic [`NVME_DATA_W-1:0] data;
    logic                    last;
  } wbeat_t;

  // NVM command set opcodes
  typedef enum logic [7:0] {
    op_write = 8'h01,
    op_read  = 8'h02
  } io_opcode_t;

  typedef enum logic [1:0] {
    st_idle,
    st_ring,
    st_wait_cpl
  } seq_state_t;

  // Half-open window check [lo, hi)
  function automatic logic in_window(input logic [`NVME_ADDR_W-1:0] addr,
                                     input logic [`NVME_ADDR_W-1:0] lo,
                                     input logic [`NVME_ADDR_W-1:0] hi);
    return (addr >= lo) && (addr < hi);
  endfunction

endpackage

// File: common/io_ctrl_if.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

interface io_ctrl_if;

  logic                       active;    // Command in flight
  nvme_host_pkg::io_opcode_t  opcode;
  logic                       cpl_done;  // Completion B accepted
  logic [`NVME_DATA_W-1:0]    cpl_entry;

  modport seq (
    output active,
    output opcode,
    input  cpl_done
  );

  modport rd_port (
    input active,
    input opcode
  );

  modport wr_port (
    input  active,
    output cpl_done,
    output cpl_entry
  );

endinterface

// File: hdl/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 8
) (
  input  logic clk,
  input  logic rstn,
  input  logic push,
  input  T     din,
  input  logic pop,
  output T     dout,
  output logic full,
  output logic empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  wire do_push = push && !full;
  wire do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  // Head entry is visible without a read cycle
  assign dout  = mem[rd_ptr];
  assign full  = (count == (PTR_W + 1)'(DEPTH));
  assign empty = (count == '0);

endmodule

// File: hdl/doorbell_writer.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module doorbell_writer (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    ring,
  input  logic [`NVME_TAIL_W-1:0] tail,
  output logic                    rang,
  // AW
  output logic [`NVME_ADDR_W-1:0] awaddr,
  output logic [`NVME_ID_W-1:0]   awid,
  output logic [`NVME_LEN_W-1:0]  awlen,
  output logic                    awvalid,
  input  logic                    awready,
  // W
  output logic [`NVME_DATA_W-1:0] wdata,
  output logic [`NVME_STRB_W-1:0] wstrb,
  output logic                    wlast,
  output logic                    wvalid,
  input  logic                    wready,
  // B
  output logic                    bready,
  input  logic                    bvalid,
  input  logic [1:0]              bresp
);

  wire aw_fire = awvalid && awready;
  wire w_fire  = wvalid && wready;
  wire b_fire  = bvalid && bready;

  // ----------------------------------------------------------------------
  // Handshake sequencing AW -> W -> B
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      rang    <= 1'b0;
      awid    <= '0;
    end else begin
      rang <= b_fire && (bresp == 2'b00);
      if (ring) awvalid <= 1'b1;
      else if (aw_fire) awvalid <= 1'b0;
      if (aw_fire) begin
        wvalid <= 1'b1;
        awid   <= awid + 1'b1;  // Next doorbell gets a fresh ID
      end else if (w_fire) begin
        wvalid <= 1'b0;
      end
      if (w_fire) bready <= 1'b1;
      else if (b_fire) bready <= 1'b0;
    end
  end

  // Single-beat payload, loaded when the doorbell is rung
  always_ff @(posedge clk) begin
    if (ring) begin
      awaddr <= `NVME_DOORBELL_ADDR;
      awlen  <= '0;
      wdata  <= {(`NVME_DATA_W / `NVME_TAIL_W){tail}};
      wstrb  <= '1;
      wlast  <= 1'b1;
    end
  end

endmodule

// File: hdl/nvme_io_sequencer.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module nvme_io_sequencer (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start_write,
  input  logic                    start_read,
  input  logic                    rang,
  output logic                    ring,
  output logic [`NVME_TAIL_W-1:0] tail,
  output logic                    busy,
  output logic                    done,
  io_ctrl_if.seq                  ctrl
);

  nvme_host_pkg::seq_state_t state;

  wire start = start_write || start_read;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= nvme_host_pkg::st_idle;
      ctrl.active <= 1'b0;
      ctrl.opcode <= nvme_host_pkg::op_write;
      ring        <= 1'b0;
      done        <= 1'b0;
      tail        <= `NVME_TAIL_W'(1);
    end else begin
      ring <= 1'b0;
      done <= 1'b0;
      case (state)
        nvme_host_pkg::st_idle: begin
          if (start) begin
            // Read wins on a tie
            ctrl.opcode <= start_read ? nvme_host_pkg::op_read : nvme_host_pkg::op_write;
            ctrl.active <= 1'b1;
            ring        <= 1'b1;
            state       <= nvme_host_pkg::st_ring;
          end
        end
        nvme_host_pkg::st_ring: begin
          if (rang) begin
            tail  <= tail + 1'b1;
            state <= nvme_host_pkg::st_wait_cpl;
          end
        end
        nvme_host_pkg::st_wait_cpl: begin
          if (ctrl.cpl_done) begin
            ctrl.active <= 1'b0;
            done        <= 1'b1;
            state       <= nvme_host_pkg::st_idle;
          end
        end
        default: state <= nvme_host_pkg::st_idle;
      endcase
    end
  end

  assign busy = ctrl.active;

endmodule

// File: host_mem/host_mem_read_port.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module host_mem_read_port (
  input  logic                    clk,
  input  logic                    rstn,
  io_ctrl_if.rd_port              ctrl,
  // AR
  input  logic [`NVME_ADDR_W-1:0] araddr,
  input  logic [`NVME_ID_W-1:0]   arid,
  input  logic [`NVME_LEN_W-1:0]  arlen,
  input  logic                    arvalid,
  output logic                    arready,
  // R
  output logic [`NVME_DATA_W-1:0] rdata,
  output logic [`NVME_ID_W-1:0]   rid,
  output logic                    rlast,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready
);

  nvme_host_pkg::addr_req_t ar_req;
  nvme_host_pkg::addr_req_t head;
  nvme_host_pkg::addr_req_t cur;
  logic                     ar_full;
  logic                     ar_empty;
  logic                     ar_pop;
  logic                     bursting;
  logic [`NVME_LEN_W-1:0]   beat_cnt;
  logic [`NVME_DATA_W-1:0]  cmd_beat;

  assign ar_req  = '{addr: araddr, id: arid, len: arlen};
  assign arready = ctrl.active && !ar_full;  // Closed between commands

  req_fifo #(
    .T     (nvme_host_pkg::addr_req_t),
    .DEPTH (`NVME_FIFO_DEPTH)
  ) ar_fifo_inst (
    .clk   (clk),
    .rstn  (rstn),
    .push  (arvalid && arready),
    .din   (ar_req),
    .pop   (ar_pop),
    .dout  (head),
    .full  (ar_full),
    .empty (ar_empty)
  );

  // ----------------------------------------------------------------------
  // Burst engine, one request at a time
  // ----------------------------------------------------------------------
  assign ar_pop = !bursting && !ar_empty;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bursting <= 1'b0;
      beat_cnt <= '0;
    end else if (ar_pop) begin
      bursting <= 1'b1;
      beat_cnt <= '0;
    end else if (rvalid && rready) begin
      if (rlast) bursting <= 1'b0;
      else beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_pop) cur <= head;
  end

  // 64-byte command entry split over two beats
  always_comb begin
    cmd_beat = '0;
    if (beat_cnt == '0) begin
      cmd_beat[0*32 +: 32] = {24'h0, ctrl.opcode};
      cmd_beat[1*32 +: 32] = 32'd1;  // NSID
      if (ctrl.opcode == nvme_host_pkg::op_write) cmd_beat[5*32 +: 32] = `NVME_META_PTR;
      cmd_beat[6*32 +: 32] = `NVME_PRP1;
    end else begin
      cmd_beat[2*32 +: 32] = `NVME_SLBA;  // DW10
    end
  end

  assign rdata  = nvme_host_pkg::in_window(cur.addr, `NVME_SQ_BASE, `NVME_SQ_END) ?
                  cmd_beat : `NVME_WR_PATTERN;
  assign rid    = cur.id;
  assign rlast  = (beat_cnt == cur.len);
  assign rresp  = 2'b00;
  assign rvalid = bursting;

endmodule

// File: host_mem/host_mem_write_port.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module host_mem_write_port (
  input  logic                    clk,
  input  logic                    rstn,
  io_ctrl_if.wr_port              ctrl,
  output logic [`NVME_DATA_W-1:0] rd_data,
  // AW
  input  logic [`NVME_ADDR_W-1:0] awaddr,
  input  logic [`NVME_ID_W-1:0]   awid,
  input  logic [`NVME_LEN_W-1:0]  awlen,
  input  logic                    awvalid,
  output logic                    awready,
  // W
  input  logic [`NVME_DATA_W-1:0] wdata,
  input  logic                    wlast,
  input  logic                    wvalid,
  output logic                    wready,
  // B
  output logic [`NVME_ID_W-1:0]   bid,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready
);

  nvme_host_pkg::addr_req_t aw_req;
  nvme_host_pkg::addr_req_t aw_head;
  nvme_host_pkg::addr_req_t cur;
  nvme_host_pkg::wbeat_t    w_beat;
  nvme_host_pkg::wbeat_t    w_head;
  logic                     aw_full;
  logic                     aw_empty;
  logic                     aw_pop;
  logic                     w_full;
  logic                     w_empty;
  logic                     w_pop;
  logic                     have_req;
  logic                     first_beat;
  logic                     cur_cq;

  assign aw_req  = '{addr: awaddr, id: awid, len: awlen};
  assign w_beat  = '{data: wdata, last: wlast};
  assign awready = ctrl.active && !aw_full;
  assign wready  = ctrl.active && !w_full;

  req_fifo #(
    .T     (nvme_host_pkg::addr_req_t),
    .DEPTH (`NVME_FIFO_DEPTH)
  ) aw_fifo_inst (
    .clk   (clk),
    .rstn  (rstn),
    .push  (awvalid && awready),
    .din   (aw_req),
    .pop   (aw_pop),
    .dout  (aw_head),
    .full  (aw_full),
    .empty (aw_empty)
  );

  req_fifo #(
    .T     (nvme_host_pkg::wbeat_t),
    .DEPTH (`NVME_FIFO_DEPTH)
  ) w_fifo_inst (
    .clk   (clk),
    .rstn  (rstn),
    .push  (wvalid && wready),
    .din   (w_beat),
    .pop   (w_pop),
    .dout  (w_head),
    .full  (w_full),
    .empty (w_empty)
  );

  // ----------------------------------------------------------------------
  // Address, then data until wlast, then one B
  // ----------------------------------------------------------------------
  assign aw_pop = !have_req && !bvalid && !aw_empty;
  assign w_pop  = have_req && !w_empty;
  assign cur_cq = nvme_host_pkg::in_window(cur.addr, `NVME_CQ_BASE, `NVME_CQ_END);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      have_req   <= 1'b0;
      first_beat <= 1'b0;
      bvalid     <= 1'b0;
    end else begin
      if (aw_pop) begin
        have_req   <= 1'b1;
        first_beat <= 1'b1;
      end else if (w_pop) begin
        first_beat <= 1'b0;
        if (w_head.last) begin
          have_req <= 1'b0;
          bvalid   <= 1'b1;
        end
      end
      if (bvalid && bready) bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_pop) cur <= aw_head;
    if (w_pop) begin
      if (!cur_cq) rd_data <= w_head.data;
      else if (first_beat) ctrl.cpl_entry <= w_head.data;  // CQE fits in beat 0
    end
  end

  assign bid           = cur.id;
  assign bresp         = 2'b00;
  assign ctrl.cpl_done = bvalid && bready && cur_cq;

endmodule

// File: hdl/nvme_host_top.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module nvme_host_top (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start_write,
  input  logic                    start_read,
  output logic                    busy,
  output logic                    done,
  output logic [`NVME_DATA_W-1:0] cpl_entry,
  output logic [`NVME_DATA_W-1:0] rd_data,
  // ----------------------------------------------------------------------
  // Outbound AXI, host to controller
  // ----------------------------------------------------------------------
  output logic [`NVME_ADDR_W-1:0] s_awaddr,
  output logic [`NVME_ID_W-1:0]   s_awid,
  output logic [`NVME_LEN_W-1:0]  s_awlen,
  output logic                    s_awvalid,
  input  logic                    s_awready,
  output logic [`NVME_DATA_W-1:0] s_wdata,
  output logic [`NVME_STRB_W-1:0] s_wstrb,
  output logic                    s_wlast,
  output logic                    s_wvalid,
  input  logic                    s_wready,
  output logic                    s_bready,
  input  logic                    s_bvalid,
  input  logic [1:0]              s_bresp,
  // ----------------------------------------------------------------------
  // Inbound AXI, controller to host memory
  // ----------------------------------------------------------------------
  input  logic [`NVME_ADDR_W-1:0] m_araddr,
  input  logic [`NVME_ID_W-1:0]   m_arid,
  input  logic [`NVME_LEN_W-1:0]  m_arlen,
  input  logic                    m_arvalid,
  output logic                    m_arready,
  output logic [`NVME_DATA_W-1:0] m_rdata,
  output logic [`NVME_ID_W-1:0]   m_rid,
  output logic                    m_rlast,
  output logic [1:0]              m_rresp,
  output logic                    m_rvalid,
  input  logic                    m_rready,
  input  logic [`NVME_ADDR_W-1:0] m_awaddr,
  input  logic [`NVME_ID_W-1:0]   m_awid,
  input  logic [`NVME_LEN_W-1:0]  m_awlen,
  input  logic                    m_awvalid,
  output logic                    m_awready,
  input  logic [`NVME_DATA_W-1:0] m_wdata,
  input  logic                    m_wlast,
  input  logic                    m_wvalid,
  output logic                    m_wready,
  output logic [`NVME_ID_W-1:0]   m_bid,
  output logic [1:0]              m_bresp,
  output logic                    m_bvalid,
  input  logic                    m_bready
);

  logic                    ring;
  logic                    rang;
  logic [`NVME_TAIL_W-1:0] tail;

  io_ctrl_if ctrl_if ();

  nvme_io_sequencer nvme_io_sequencer_inst (
    .clk         (clk),
    .rstn        (rstn),
    .start_write (start_write),
    .start_read  (start_read),
    .rang        (rang),
    .ring        (ring),
    .tail        (tail),
    .busy        (busy),
    .done        (done),
    .ctrl        (ctrl_if)
  );

  doorbell_writer doorbell_writer_inst (
    .clk     (clk),
    .rstn    (rstn),
    .ring    (ring),
    .tail    (tail),
    .rang    (rang),
    .awaddr  (s_awaddr),
    .awid    (s_awid),
    .awlen   (s_awlen),
    .awvalid (s_awvalid),
    .awready (s_awready),
    .wdata   (s_wdata),
    .wstrb   (s_wstrb),
    .wlast   (s_wlast),
    .wvalid  (s_wvalid),
    .wready  (s_wready),
    .bready  (s_bready),
    .bvalid  (s_bvalid),
    .bresp   (s_bresp)
  );

  host_mem_read_port host_mem_read_port_inst (
    .clk     (clk),
    .rstn    (rstn),
    .ctrl    (ctrl_if),
    .araddr  (m_araddr),
    .arid    (m_arid),
    .arlen   (m_arlen),
    .arvalid (m_arvalid),
    .arready (m_arready),
    .rdata   (m_rdata),
    .rid     (m_rid),
    .rlast   (m_rlast),
    .rresp   (m_rresp),
    .rvalid  (m_rvalid),
    .rready  (m_rready)
  );

  host_mem_write_port host_mem_write_port_inst (
    .clk     (clk),
    .rstn    (rstn),
    .ctrl    (ctrl_if),
    .rd_data (rd_data),
    .awaddr  (m_awaddr),
    .awid    (m_awid),
    .awlen   (m_awlen),
    .awvalid (m_awvalid),
    .awready (m_awready),
    .wdata   (m_wdata),
    .wlast   (m_wlast),
    .wvalid  (m_wvalid),
    .wready  (m_wready),
    .bid     (m_bid),
    .bresp   (m_bresp),
    .bvalid  (m_bvalid),
    .bready  (m_bready)
  );

  assign cpl_entry = ctrl_if.cpl_entry;

endmodule

// File: verification/nvme_ctrl_model.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module nvme_ctrl_model (
  input  logic                    clk,
  // Outbound AXI, doorbell side
  input  logic [`NVME_ADDR_W-1:0] s_awaddr,
  input  logic [`NVME_ID_W-1:0]   s_awid,
  input  logic [`NVME_LEN_W-1:0]  s_awlen,
  input  logic                    s_awvalid,
  output logic                    s_awready,
  input  logic [`NVME_DATA_W-1:0] s_wdata,
  input  logic [`NVME_STRB_W-1:0] s_wstrb,
  input  logic                    s_wlast,
  input  logic                    s_wvalid,
  output logic                    s_wready,
  input  logic                    s_bready,
  output logic                    s_bvalid,
  output logic [1:0]              s_bresp,
  // Inbound AXI, host memory side
  output logic [`NVME_ADDR_W-1:0] m_araddr,
  output logic [`NVME_ID_W-1:0]   m_arid,
  output logic [`NVME_LEN_W-1:0]  m_arlen,
  output logic                    m_arvalid,
  input  logic                    m_arready,
  input  logic [`NVME_DATA_W-1:0] m_rdata,
  input  logic [`NVME_ID_W-1:0]   m_rid,
  input  logic                    m_rlast,
  input  logic [1:0]              m_rresp,
  input  logic                    m_rvalid,
  output logic                    m_rready,
  output logic [`NVME_ADDR_W-1:0] m_awaddr,
  output logic [`NVME_ID_W-1:0]   m_awid,
  output logic [`NVME_LEN_W-1:0]  m_awlen,
  output logic                    m_awvalid,
  input  logic                    m_awready,
  output logic [`NVME_DATA_W-1:0] m_wdata,
  output logic                    m_wlast,
  output logic                    m_wvalid,
  input  logic                    m_wready,
  input  logic [`NVME_ID_W-1:0]   m_bid,
  input  logic [1:0]              m_bresp,
  input  logic                    m_bvalid,
  output logic                    m_bready
);

  localparam int TIMEOUT = 2000;

  // Last observed doorbell, read burst and write response
  logic [`NVME_ID_W-1:0]   db_id;
  logic [`NVME_LEN_W-1:0]  db_len;
  logic [`NVME_STRB_W-1:0] db_strb;
  logic                    db_last;
  logic [`NVME_DATA_W-1:0] beat_data [4];
  logic [`NVME_ID_W-1:0]   beat_id [4];
  logic                    beat_last [4];
  logic [1:0]              beat_resp [4];
  logic [`NVME_DATA_W-1:0] last_wdata;
  logic [`NVME_ID_W-1:0]   bid_seen;
  logic [1:0]              bresp_seen;
  logic                    extra_b;

  initial begin
    s_awready = 1'b1;  // Doorbell side never stalls
    s_wready  = 1'b1;
    s_bvalid  = 1'b0;
    s_bresp   = 2'b00;
    m_araddr  = '0;
    m_arid    = '0;
    m_arlen   = '0;
    m_arvalid = 1'b0;
    m_rready  = 1'b0;
    m_awaddr  = '0;
    m_awid    = '0;
    m_awlen   = '0;
    m_awvalid = 1'b0;
    m_wdata   = '0;
    m_wlast   = 1'b0;
    m_wvalid  = 1'b0;
    m_bready  = 1'b0;
  end

  function automatic logic [`NVME_DATA_W-1:0] random_beat();
    logic [`NVME_DATA_W-1:0] v;
    for (int i = 0; i < `NVME_DATA_W / 32; i++) v[i*32 +: 32] = $urandom;
    return v;
  endfunction

  // ------------------------------------------------------------------
  // All tasks start and end right after a falling edge
  // ------------------------------------------------------------------
  task automatic take_doorbell(output logic [`NVME_ADDR_W-1:0] addr,
                               output logic [`NVME_DATA_W-1:0] data, output bit ok);
    int waited;
    waited = 0;
    while (!s_awvalid && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    ok     = s_awvalid;
    addr   = s_awaddr;
    db_id  = s_awid;
    db_len = s_awlen;
    @(negedge clk);
    while (!s_wvalid && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    ok      = ok && s_wvalid;
    data    = s_wdata;
    db_strb = s_wstrb;
    db_last = s_wlast;
    @(negedge clk);
    s_bvalid = 1'b1;
    while (!s_bready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    ok = ok && s_bready;
    @(negedge clk);
    s_bvalid = 1'b0;
  endtask

  task automatic read_burst(input logic [`NVME_ADDR_W-1:0] addr,
                            input logic [`NVME_ID_W-1:0] id, input int len, output bit ok);
    int waited;
    int beat;
    m_araddr  = addr;
    m_arid    = id;
    m_arlen   = len;
    m_arvalid = 1'b1;
    waited    = 0;
    while (!m_arready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    ok = m_arready;
    @(negedge clk);
    m_arvalid = 1'b0;
    beat      = 0;
    while (beat <= len && waited < TIMEOUT) begin
      m_rready = $urandom % 2;  // Random stalls
      if (m_rvalid && m_rready) begin
        beat_data[beat] = m_rdata;
        beat_id[beat]   = m_rid;
        beat_last[beat] = m_rlast;
        beat_resp[beat] = m_rresp;
        beat++;
      end
      @(negedge clk);
      waited++;
    end
    m_rready = 1'b0;
    ok = ok && (beat > len);
  endtask

  task automatic write_burst(input logic [`NVME_ADDR_W-1:0] addr,
                             input logic [`NVME_ID_W-1:0] id, input int len, output bit ok);
    int waited;
    m_awaddr  = addr;
    m_awid    = id;
    m_awlen   = len;
    m_awvalid = 1'b1;
    waited    = 0;
    while (!m_awready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    ok = m_awready;
    @(negedge clk);
    m_awvalid = 1'b0;
    for (int b = 0; b <= len; b++) begin
      m_wdata  = random_beat();
      m_wlast  = (b == len);
      m_wvalid = 1'b1;
      while (!m_wready && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      ok         = ok && m_wready;
      last_wdata = m_wdata;
      @(negedge clk);
    end
    m_wvalid = 1'b0;
    m_wlast  = 1'b0;
    m_bready = $urandom % 2;
    while (!(m_bvalid && m_bready) && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
      m_bready = $urandom % 2;
    end
    ok         = ok && m_bvalid && m_bready;
    bid_seen   = m_bid;
    bresp_seen = m_bresp;
    @(negedge clk);
    m_bready = 1'b0;
    extra_b  = m_bvalid;  // A second B here would be a duplicate
  endtask

endmodule

// File: verification/nvme_host_tb.sv
`timescale 1ns/1ps
`include "nvme_host_settings.svh"

module nvme_host_tb;

  localparam int TIMEOUT = 2000;

  logic                    clk;
  logic                    rstn;
  logic                    start_write;
  logic                    start_read;
  logic                    busy;
  logic                    done;
  logic [`NVME_DATA_W-1:0] cpl_entry;
  logic [`NVME_DATA_W-1:0] rd_data;
  logic [`NVME_ADDR_W-1:0] s_awaddr;
  logic [`NVME_ID_W-1:0]   s_awid;
  logic [`NVME_LEN_W-1:0]  s_awlen;
  logic                    s_awvalid, s_awready;
  logic [`NVME_DATA_W-1:0] s_wdata;
  logic [`NVME_STRB_W-1:0] s_wstrb;
  logic                    s_wlast, s_wvalid, s_wready;
  logic                    s_bready, s_bvalid;
  logic [1:0]              s_bresp;
  logic [`NVME_ADDR_W-1:0] m_araddr, m_awaddr;
  logic [`NVME_ID_W-1:0]   m_arid, m_rid, m_awid, m_bid;
  logic [`NVME_LEN_W-1:0]  m_arlen, m_awlen;
  logic                    m_arvalid, m_arready;
  logic [`NVME_DATA_W-1:0] m_rdata, m_wdata;
  logic                    m_rlast, m_rvalid, m_rready;
  logic [1:0]              m_rresp, m_bresp;
  logic                    m_awvalid, m_awready;
  logic                    m_wlast, m_wvalid, m_wready;
  logic                    m_bvalid, m_bready;

  logic [`NVME_TAIL_W-1:0] exp_tail;
  logic [`NVME_ID_W-1:0]   exp_db_id;
  int                      done_count = 0;
  int                      cmd_count;
  int                      seed_value;

  nvme_host_top nvme_host_top_inst (.*);
  nvme_ctrl_model ctrl_model_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk) if (done) done_count++;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input logic [`NVME_DATA_W-1:0] got, input logic [`NVME_DATA_W-1:0] exp,
                       input string what);
    if (got !== exp)
      fail_run($sformatf("Error at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic require_seen(input bit ok, input string what);
    if (!ok) fail_run({"Timeout: no response within 2000 cycles while waiting for ", what});
  endtask

  // Expected 64-byte command entry with DW0..DW7 in beat 0
  function automatic logic [`NVME_DATA_W-1:0] cmd_template(input bit is_read, input int beat);
    logic [`NVME_DATA_W-1:0] t;
    t = '0;
    if (beat == 0) begin
      t[31:0]  = is_read ? 32'd2 : 32'd1;
      t[63:32] = 32'd1;
      if (!is_read) t[191:160] = `NVME_META_PTR;
      t[223:192] = `NVME_PRP1;
    end else begin
      t[95:64] = `NVME_SLBA;  // DW10
    end
    return t;
  endfunction

  // Between commands nothing moves and inbound ports stay closed
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      check(busy, 1'b0, "busy while idle");
      check(s_awvalid, 1'b0, "doorbell awvalid while idle");
      check(m_arready, 1'b0, "arready while idle");
      check(m_awready, 1'b0, "awready while idle");
      check(m_wready, 1'b0, "wready while idle");
      @(negedge clk);
    end
  endtask

  task automatic run_command(input int kind);
    bit                      is_read;
    bit                      ok;
    logic [`NVME_ADDR_W-1:0] db_addr;
    logic [`NVME_DATA_W-1:0] db_data;
    logic [`NVME_ID_W-1:0]   id;
    int                      nb;
    int                      len;
    int                      waited;
    is_read     = (kind != 0);  // Kind 2 pulses both and read wins
    start_write = (kind != 1);
    start_read  = (kind != 0);
    @(negedge clk);
    start_write = 1'b0;
    start_read  = 1'b0;
    check(busy, 1'b1, "busy after start");
    ctrl_model_inst.take_doorbell(db_addr, db_data, ok);
    require_seen(ok, "the doorbell write");
    check(db_addr, `NVME_DOORBELL_ADDR, "doorbell address");
    check(db_data, {(`NVME_DATA_W / `NVME_TAIL_W){exp_tail}}, "doorbell data");
    check(ctrl_model_inst.db_len, 0, "doorbell awlen");
    check(ctrl_model_inst.db_strb, {`NVME_STRB_W{1'b1}}, "doorbell wstrb");
    check(ctrl_model_inst.db_last, 1'b1, "doorbell wlast");
    if (cmd_count == 0) exp_db_id = ctrl_model_inst.db_id;
    check(ctrl_model_inst.db_id, exp_db_id, "doorbell awid");
    exp_db_id++;
    exp_tail++;
    id = $urandom;
    ctrl_model_inst.read_burst(`NVME_SQ_BASE, id, 1, ok);
    require_seen(ok, "the command fetch");
    for (int b = 0; b < 2; b++) begin
      check(ctrl_model_inst.beat_data[b], cmd_template(is_read, b), "command beat");
      check(ctrl_model_inst.beat_id[b], id, "command rid");
      check(ctrl_model_inst.beat_last[b], b == 1, "command rlast");
      check(ctrl_model_inst.beat_resp[b], 2'b00, "command rresp");
    end
    start_write = 1'b1;  // Stray pulse while busy
    @(negedge clk);
    start_write = 1'b0;
    nb = 1 + $urandom % 3;
    for (int k = 0; k < nb; k++) begin
      id  = $urandom;
      len = $urandom % 4;
      if (is_read) begin
        ctrl_model_inst.write_burst(`NVME_PRP1 + 32'h100 * k, id, len, ok);
        require_seen(ok, "a read-data write burst");
        check(ctrl_model_inst.bid_seen, id, "data bid");
        check(ctrl_model_inst.bresp_seen, 2'b00, "data bresp");
        check(ctrl_model_inst.extra_b, 1'b0, "extra B response");
      end else begin
        ctrl_model_inst.read_burst(`NVME_PRP1 + 32'h100 * k, id, len, ok);
        require_seen(ok, "a write-data read burst");
        for (int b = 0; b <= len; b++) begin
          check(ctrl_model_inst.beat_data[b], `NVME_WR_PATTERN, "write data beat");
          check(ctrl_model_inst.beat_id[b], id, "write data rid");
          check(ctrl_model_inst.beat_last[b], b == len, "write data rlast");
          check(ctrl_model_inst.beat_resp[b], 2'b00, "write data rresp");
        end
      end
    end
    if (is_read) check(rd_data, ctrl_model_inst.last_wdata, "rd_data");
    id = $urandom;
    ctrl_model_inst.write_burst(`NVME_CQ_BASE, id, 0, ok);
    require_seen(ok, "the completion write");
    check(ctrl_model_inst.bid_seen, id, "completion bid");
    check(ctrl_model_inst.bresp_seen, 2'b00, "completion bresp");
    check(ctrl_model_inst.extra_b, 1'b0, "extra completion B response");
    waited = 0;
    while (!done && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    require_seen(done, "the done pulse");
    check(cpl_entry, ctrl_model_inst.last_wdata, "completion entry");
    cmd_count++;
    @(negedge clk);
    check_idle(5);
    check(done_count, cmd_count, "done pulse count");
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    seed_value  = $urandom(38);
    rstn        = 1'b0;
    start_write = 1'b0;
    start_read  = 1'b0;
    exp_tail    = 1;
    exp_db_id   = '0;
    cmd_count   = 0;
    repeat (3) @(negedge clk);
    rstn = 1'b1;
    check(done, 1'b0, "done after reset");
    check(s_wvalid, 1'b0, "doorbell wvalid after reset");
    check(s_bready, 1'b0, "doorbell bready after reset");
    check(m_rvalid, 1'b0, "rvalid after reset");
    check(m_bvalid, 1'b0, "bvalid after reset");
    check_idle(4);
    repeat (8) run_command($urandom % 3);
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: nvme_host.f
+incdir+common
common/nvme_host_pkg.sv
common/io_ctrl_if.sv
hdl/req_fifo.sv
hdl/doorbell_writer.sv
hdl/nvme_io_sequencer.sv
host_mem/host_mem_read_port.sv
host_mem/host_mem_write_port.sv
hdl/nvme_host_top.sv
verification/nvme_ctrl_model.sv
verification/nvme_host_tb.sv
